/* Bender.yml */
package:
  name: phase_demod

sources:
  - source/demod_types_pkg.sv
  - source/cordic_pkg.sv
  - source/cordic_atan2.sv
  - source/angle_fifo.sv
  - source/phase_diff.sv
  - source/phase_demod.sv
  - target: simulation
    files:
      - verif/phase_demod_assert.sv
      - verif/phase_demod_tb.sv

/* phase_demod.f */
source/demod_types_pkg.sv
source/cordic_pkg.sv
source/cordic_atan2.sv
source/angle_fifo.sv
source/phase_diff.sv
source/phase_demod.sv
verif/phase_demod_assert.sv
verif/phase_demod_tb.sv

/* source/angle_fifo.sv */
// ------------------------------------------------------------
// synchronous FIFO for angle/tag pairs
// ------------------------------------------------------------

`timescale 1ns/1ns

module angle_fifo (
    input  logic                                       clk,
    input  logic                                       reset,

    input  logic [demod_types_pkg::angle_width-1:0]    c_angle,
    input  logic [demod_types_pkg::tag_width-1:0]      c_tag,
    input  logic                                       c_valid,
    output logic                                       c_ready,

    output logic [demod_types_pkg::angle_width-1:0]    f_angle,
    output logic [demod_types_pkg::tag_width-1:0]      f_tag,
    output logic                                       f_valid,
    input  logic                                       f_ready
);

    import demod_types_pkg::*;

    logic [angle_width-1:0]      angle_mem [fifo_depth];
    logic [tag_width-1:0]        tag_mem   [fifo_depth];

    logic [fifo_ptr_width-1:0]   wr_ptr;
    logic [fifo_ptr_width-1:0]   rd_ptr;
    logic [fifo_count_width-1:0] count;

    logic                        full;
    logic                        wr_en;
    logic                        rd_en;

    assign full    = (count == fifo_count_width'(fifo_depth));
    assign f_valid = (count != '0);

    // a read in the same cycle frees the slot
    assign c_ready = !full || f_ready;

    assign wr_en = c_valid && c_ready;
    assign rd_en = f_valid && f_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            angle_mem[wr_ptr] <= c_angle;
            tag_mem[wr_ptr]   <= c_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry
    assign f_angle = angle_mem[rd_ptr];
    assign f_tag   = tag_mem[rd_ptr];

endmodule

/* source/cordic_atan2.sv */
// ------------------------------------------------------------
// pipelined CORDIC vectoring unit, (x, y, tag) to (angle, tag)
// ------------------------------------------------------------

`timescale 1ns/1ns

module cordic_atan2 (
    input  logic                                            clk,
    input  logic                                            reset,

    input  logic signed [demod_types_pkg::sample_width-1:0] s_x,
    input  logic signed [demod_types_pkg::sample_width-1:0] s_y,
    input  logic        [demod_types_pkg::tag_width-1:0]    s_tag,
    input  logic                                            s_valid,
    output logic                                            s_ready,

    output logic        [demod_types_pkg::angle_width-1:0]  c_angle,
    output logic        [demod_types_pkg::tag_width-1:0]    c_tag,
    output logic                                            c_valid,
    input  logic                                            c_ready
);

    import demod_types_pkg::*;
    import cordic_pkg::*;

    // ------------------------------------------------------------
    // pipeline registers
    // ------------------------------------------------------------

    logic                           advance;
    logic [cordic_stages-1:0]       stage_valid;

    logic signed [xy_width-1:0]     x_ext;
    logic signed [xy_width-1:0]     y_ext;

    // x/y are not needed past the last micro-rotation
    logic signed [xy_width-1:0]     x_r     [cordic_stages-1];
    logic signed [xy_width-1:0]     y_r     [cordic_stages-1];
    logic        [angle_width-1:0]  angle_r [cordic_stages];
    logic        [tag_width-1:0]    tag_r   [cordic_stages];

    // whole pipeline moves together
    assign advance = !stage_valid[cordic_stages-1] || c_ready;
    assign s_ready = advance;

    // sign extend to internal width
    assign x_ext = s_x;
    assign y_ext = s_y;

    // ------------------------------------------------------------
    // valid shift register
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[cordic_stages-2:0], s_valid};
        end
    end

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (advance) begin
            // stage 0, swap x/y and start from 90 or 270 degrees
            tag_r[0] <= s_tag;
            if (!s_y[sample_width-1]) begin
                x_r[0]     <= y_ext <<< pre_shift;
                y_r[0]     <= -(x_ext <<< pre_shift);
                angle_r[0] <= angle_90;
            end else begin
                x_r[0]     <= -(y_ext <<< pre_shift);
                y_r[0]     <= x_ext <<< pre_shift;
                angle_r[0] <= angle_270;
            end

            // angle and tag through every micro-rotation
            for (int i = 1; i < cordic_stages; i++) begin
                tag_r[i] <= tag_r[i-1];
                if (!y_r[i-1][xy_width-1]) begin
                    angle_r[i] <= angle_r[i-1] + atan_table[i-1];
                end else begin
                    angle_r[i] <= angle_r[i-1] - atan_table[i-1];
                end
            end

            // rotate toward y == 0
            for (int i = 1; i < cordic_stages - 1; i++) begin
                if (!y_r[i-1][xy_width-1]) begin
                    x_r[i] <= x_r[i-1] + (y_r[i-1] >>> (i - 1));
                    y_r[i] <= y_r[i-1] - (x_r[i-1] >>> (i - 1));
                end else begin
                    x_r[i] <= x_r[i-1] - (y_r[i-1] >>> (i - 1));
                    y_r[i] <= y_r[i-1] + (x_r[i-1] >>> (i - 1));
                end
            end
        end
    end

    // ------------------------------------------------------------
    // output
    // ------------------------------------------------------------

    assign c_angle = angle_r[cordic_stages-1];
    assign c_tag   = tag_r[cordic_stages-1];
    assign c_valid = stage_valid[cordic_stages-1];

endmodule

/* source/cordic_pkg.sv */
// ------------------------------------------------------------
// CORDIC stage count, start angles and arctangent table
// ------------------------------------------------------------

package cordic_pkg;

    import demod_types_pkg::*;

    // ------------------------------------------------------------
    // pipeline geometry
    // ------------------------------------------------------------

    // pre-rotation plus 16 micro-rotations
    localparam int cordic_stages = 17;

    // internal x/y width
    localparam int xy_width = sample_width + angle_width;

    // left shift of the input samples at the pre-rotation
    // two bits of headroom for the CORDIC gain and the diagonal
    localparam int pre_shift = angle_width - 2;

    // ------------------------------------------------------------
    // start angles of the pre-rotation
    // ------------------------------------------------------------

    localparam logic [angle_width-1:0] angle_90 = angle_width'(16384);
    localparam logic [angle_width-1:0] angle_270 = angle_width'(49152);

    // ------------------------------------------------------------
    // atan(2^-i) in scaled radians, rounded
    // ------------------------------------------------------------

    localparam logic [0:cordic_stages-2][angle_width-1:0] atan_table = '{
        16'd8192,
        16'd4836,
        16'd2555,
        16'd1297,
        16'd651,
        16'd326,
        16'd163,
        16'd81,
        16'd41,
        16'd20,
        16'd10,
        16'd5,
        16'd3,
        16'd1,
        16'd1,
        16'd0
    };

    // last entries round to 0 or 1 LSB
    // residual error stays well inside a few LSB

endpackage

/* source/demod_types_pkg.sv */
// ------------------------------------------------------------
// sample, tag, angle and FIFO widths, differencer state enum
// ------------------------------------------------------------

package demod_types_pkg;

    // ------------------------------------------------------------
    // stream widths
    // ------------------------------------------------------------

    // x and y, signed two's complement
    localparam int sample_width = 16;

    // user tag carried alongside each sample
    localparam int tag_width = 8;

    // scaled radians, 65536 is one full turn
    localparam int angle_width = 16;

    // ------------------------------------------------------------
    // angle FIFO
    // ------------------------------------------------------------

    localparam int fifo_depth = 8;
    localparam int fifo_ptr_width = $clog2(fifo_depth);

    // count must reach fifo_depth itself
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    // ------------------------------------------------------------
    // differencer
    // ------------------------------------------------------------

    // idle means no previous angle yet
    typedef enum logic [0:0] {
        diff_idle,
        diff_run
    } diff_state_t;

endpackage

/* source/phase_demod.sv */
// ------------------------------------------------------------
// phase demodulator top, CORDIC, angle FIFO and differencer
// ------------------------------------------------------------

`timescale 1ns/1ns

module phase_demod (
    input  logic                                            clk,
    input  logic                                            reset,

    input  logic signed [demod_types_pkg::sample_width-1:0] s_x,
    input  logic signed [demod_types_pkg::sample_width-1:0] s_y,
    input  logic        [demod_types_pkg::tag_width-1:0]    s_tag,
    input  logic                                            s_valid,
    output logic                                            s_ready,

    output logic        [demod_types_pkg::angle_width-1:0]  m_angle,
    output logic        [demod_types_pkg::angle_width-1:0]  m_delta,
    output logic        [demod_types_pkg::tag_width-1:0]    m_tag,
    output logic                                            m_valid,
    input  logic                                            m_ready
);

    import demod_types_pkg::*;

    // pipeline to FIFO
    logic [angle_width-1:0] c_angle;
    logic [tag_width-1:0]   c_tag;
    logic                   c_valid;
    logic                   c_ready;

    // FIFO to differencer
    logic [angle_width-1:0] f_angle;
    logic [tag_width-1:0]   f_tag;
    logic                   f_valid;
    logic                   f_ready;

    cordic_atan2 i_cordic (
        .clk     (clk),
        .reset   (reset),
        .s_x     (s_x),
        .s_y     (s_y),
        .s_tag   (s_tag),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .c_angle (c_angle),
        .c_tag   (c_tag),
        .c_valid (c_valid),
        .c_ready (c_ready)
    );

    angle_fifo i_fifo (
        .clk     (clk),
        .reset   (reset),
        .c_angle (c_angle),
        .c_tag   (c_tag),
        .c_valid (c_valid),
        .c_ready (c_ready),
        .f_angle (f_angle),
        .f_tag   (f_tag),
        .f_valid (f_valid),
        .f_ready (f_ready)
    );

    phase_diff i_diff (
        .clk     (clk),
        .reset   (reset),
        .f_angle (f_angle),
        .f_tag   (f_tag),
        .f_valid (f_valid),
        .f_ready (f_ready),
        .m_angle (m_angle),
        .m_delta (m_delta),
        .m_tag   (m_tag),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

/* source/phase_diff.sv */
// ------------------------------------------------------------
// phase differencer, wrapped delta of successive angles
// ------------------------------------------------------------

`timescale 1ns/1ns

module phase_diff (
    input  logic                                       clk,
    input  logic                                       reset,

    input  logic [demod_types_pkg::angle_width-1:0]    f_angle,
    input  logic [demod_types_pkg::tag_width-1:0]      f_tag,
    input  logic                                       f_valid,
    output logic                                       f_ready,

    output logic [demod_types_pkg::angle_width-1:0]    m_angle,
    output logic [demod_types_pkg::angle_width-1:0]    m_delta,
    output logic [demod_types_pkg::tag_width-1:0]      m_tag,
    output logic                                       m_valid,
    input  logic                                       m_ready
);

    import demod_types_pkg::*;

    diff_state_t state;
    logic        accept;

    // output register empty or being drained
    assign f_ready = !m_valid || m_ready;
    assign accept  = f_valid && f_ready;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= diff_idle;
            m_valid <= 1'b0;
        end else begin
            if (accept) begin
                m_valid <= 1'b1;
                state   <= diff_run;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------

    // m_angle still holds the previous angle when the next one arrives
    always_ff @(posedge clk) begin
        if (accept) begin
            m_angle <= f_angle;
            m_tag   <= f_tag;
            case (state)
                diff_idle: m_delta <= '0;
                diff_run:  m_delta <= f_angle - m_angle;
                default:   m_delta <= '0;
            endcase
        end
    end

endmodule

/* verif/phase_demod_assert.sv */
// ------------------------------------------------------------
// bound assertions on the output handshake and the FIFO count
// ------------------------------------------------------------

`timescale 1ns/1ns

module phase_demod_assert (
    input logic                                         clk,
    input logic                                         reset,
    input logic [demod_types_pkg::angle_width-1:0]      m_angle,
    input logic [demod_types_pkg::angle_width-1:0]      m_delta,
    input logic [demod_types_pkg::tag_width-1:0]        m_tag,
    input logic                                         m_valid,
    input logic                                         m_ready,
    input logic [demod_types_pkg::fifo_count_width-1:0] fifo_count
);

    import demod_types_pkg::*;

    // count of failed assertions
    int failures = 0;

    // stalled output keeps its data
    assert property (@(posedge clk) disable iff (reset)
        m_valid && !m_ready |=>
            m_valid && $stable(m_angle) && $stable(m_delta) && $stable(m_tag))
        else begin
            $error("output changed while m_ready was low");
            failures++;
        end

    assert property (@(posedge clk) reset |=> !m_valid)
        else begin
            $error("m_valid high in the first cycle after reset");
            failures++;
        end

    assert property (@(posedge clk) disable iff (reset)
        fifo_count <= fifo_count_width'(fifo_depth))
        else begin
            $error("FIFO count above its depth");
            failures++;
        end

endmodule

bind phase_demod phase_demod_assert i_assert (
    .clk        (clk),
    .reset      (reset),
    .m_angle    (m_angle),
    .m_delta    (m_delta),
    .m_tag      (m_tag),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .fifo_count (i_fifo.count)
);

/* verif/phase_demod_tb.sv */
// ------------------------------------------------------------
// testbench for the phase demodulator, stimulus and checks
// ------------------------------------------------------------

`timescale 1ns/1ns

module phase_demod_tb;

    import demod_types_pkg::*;

    localparam int wait_limit = 400;

    logic                           clk = 1'b0;
    logic                           reset;
    logic signed [sample_width-1:0] s_x;
    logic signed [sample_width-1:0] s_y;
    logic [tag_width-1:0]           s_tag;
    logic                           s_valid;
    logic                           s_ready;
    logic [angle_width-1:0]         m_angle;
    logic [angle_width-1:0]         m_delta;
    logic [tag_width-1:0]           m_tag;
    logic                           m_valid;
    logic                           m_ready;

    logic [31:0]                    stim_rng = 32'hcb4d_1735;
    logic [31:0]                    ready_rng = 32'hcb4d_1735;
    logic [angle_width-1:0]         exp_angles [$];
    logic [angle_width-1:0]         prev_angle;
    logic                           seen_output = 1'b0;
    logic                           full_rate = 1'b0;
    logic                           burst_done = 1'b0;
    int                             sent = 0;
    int                             delivered = 0;
    int                             value_errors = 0;
    int                             other_errors = 0;

    always #10 clk = ~clk;

    phase_demod i_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    // reference angle, one turn is 65536
    function automatic logic [angle_width-1:0] model_angle(input int x, input int y);
        real turns;
        turns = $atan2(real'(y), real'(x)) / (2.0 * 3.14159265358979);
        return angle_width'($rtoi($floor(turns * 65536.0 + 0.5)) & 32'hffff);
    endfunction

    function automatic logic angle_close(input logic [angle_width-1:0] a,
                                         input logic [angle_width-1:0] b);
        logic signed [angle_width-1:0] d;
        d = a - b;
        return d >= -3 && d <= 3;
    endfunction

    task automatic show_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h (tag %0d)", name, got, want, m_tag);
        value_errors++;
    endtask

    task automatic end_run();
        int assert_fails;
        assert_fails = i_dut.i_assert.failures;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_fails);
        if (value_errors == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timeout: %s", what);
        other_errors++;
    endtask

    task automatic check_output();
        logic [angle_width-1:0] exp_angle;
        logic [angle_width-1:0] exp_delta;
        exp_angle = exp_angles.pop_front();
        exp_delta = seen_output ? m_angle - prev_angle : '0;
        assert (angle_close(m_angle, exp_angle))
            else show_value("m_angle", m_angle, exp_angle);
        assert (m_tag == tag_width'(delivered))
            else show_value("m_tag", m_tag, tag_width'(delivered));
        assert (m_delta == exp_delta)
            else show_value("m_delta", m_delta, exp_delta);
        prev_angle = m_angle;
        seen_output = 1'b1;
        delivered++;
    endtask

    // ------------------------------------------------------------
    // reference queue and output checks
    // ------------------------------------------------------------

    always @(posedge clk) begin
        if (!reset && s_valid && s_ready) begin
            exp_angles.push_back(model_angle(s_x, s_y));
        end
        if (!reset && m_valid && m_ready) begin
            check_output();
        end
    end

    task automatic send_sample(input int x, input int y);
        int cycles;
        s_x <= sample_width'(x);
        s_y <= sample_width'(y);
        s_tag <= tag_width'(sent);
        s_valid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!s_ready && cycles < wait_limit);
        if (!s_ready) begin
            timed_out("sample was never accepted");
        end else begin
            if (full_rate) begin
                assert (cycles == 1) else begin
                    $display("s_ready dropped while streaming at full rate");
                    other_errors++;
                end
            end
            sent++;
        end
    endtask

    task automatic send_random();
        int x;
        stim_rng = xorshift32(stim_rng);
        x = $signed(stim_rng[15:0]);
        // keeps the magnitude at 256 or more
        if (x > -256 && x < 256) begin
            x = x + 512;
        end
        send_sample(x, $signed(stim_rng[31:16]));
    endtask

    task automatic drive_backpressure();
        int cycles;
        m_ready <= 1'b0;
        repeat (30) @(posedge clk);
        cycles = 0;
        while (!burst_done && cycles < 20 * wait_limit) begin
            ready_rng = xorshift32(ready_rng);
            m_ready <= ready_rng[9];
            @(posedge clk);
            cycles++;
        end
        if (!burst_done) begin
            timed_out("stalled burst did not finish");
        end
        m_ready <= 1'b1;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (delivered != sent && cycles < wait_limit);
        if (delivered != sent) begin
            timed_out("outputs did not drain");
        end
        @(posedge clk);
    endtask

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------

    initial begin
        reset = 1'b1;
        s_x = '0;
        s_y = '0;
        s_tag = '0;
        s_valid = 1'b0;
        m_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // axis and diagonal points, then random samples at full rate
        full_rate = 1'b1;
        send_sample(1000, 0);
        send_sample(0, 1000);
        send_sample(-1000, 0);
        send_sample(0, -1000);
        send_sample(700, 700);
        repeat (100) send_random();
        s_valid <= 1'b0;
        wait_drain();

        // output held low, then toggled at random
        full_rate = 1'b0;
        fork
            begin
                repeat (60) send_random();
                s_valid <= 1'b0;
                burst_done = 1'b1;
            end
            drive_backpressure();
        join
        wait_drain();
        end_run();
    end

endmodule
